/* filelist.f */
+incdir+src
src/cpuPkg.sv
src/alu.sv
src/controlUnit.sv
src/datapath.sv
src/memoryUnit.sv
src/cpuCore.sv
test/clockGen.sv
test/cpuTb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module cpuTb -f filelist.f -o cpuSim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit $status
fi

./obj_dir/cpuSim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

/* src/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  cpuPkg::word_t  a,
  input  cpuPkg::word_t  b,
  input  cpuPkg::aluOp_t op,
  output cpuPkg::word_t  result,
  output logic           zero
);

  logic lessThan;

  // signed compare for SLT
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      cpuPkg::ADD: result = a + b;
      cpuPkg::SUB: result = a - b;
      cpuPkg::AND: result = a & b;
      cpuPkg::OR:  result = a | b;
      cpuPkg::SLT: result = {31'd0, lessThan};
      default:     result = '0;
    endcase
  end

  // equal operands under SUB give zero
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* src/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module controlUnit (
  input  wire              Load,
  input  wire              reset,
  input  cpuPkg::opcode_t  opCode,
  input  cpuPkg::opcode_t  funct,
  input  wire              zero,
  input  wire              MOC,
  output logic             memEnable,
  output logic             RW,
  output logic             irLoad,
  output logic             pcLoad,
  output logic             npcLoad,
  output logic             marLoad,
  output logic             mdrLoad,
  output logic             mdrSource,
  output logic             pcSelect,
  output logic             immediate,
  output logic             rfSource,
  output logic             regWrite,
  output logic             jump,
  output logic             branch,
  output logic [1:0]       aluSrc,
  output cpuPkg::aluOp_t   aluCode,
  output logic             retired
);

  cpuPkg::ctrlState_t state;
  cpuPkg::ctrlState_t nextState;
  cpuPkg::aluOp_t     rtypeOp;
  logic               rtypeKnown;
  logic               isRtype;
  logic               isAddiu;
  logic               isLw;
  logic               isSw;
  logic               isBeq;
  logic               isJ;
  logic               branchTaken;

  // funct decode for the supported R-type set
  always_comb begin
    rtypeKnown = 1'b1;
    case (funct)
      `FN_ADDU: rtypeOp = cpuPkg::ADD;
      `FN_SUBU: rtypeOp = cpuPkg::SUB;
      `FN_AND:  rtypeOp = cpuPkg::AND;
      `FN_OR:   rtypeOp = cpuPkg::OR;
      `FN_SLT:  rtypeOp = cpuPkg::SLT;
      default: begin
        rtypeOp    = cpuPkg::ADD;
        rtypeKnown = 1'b0;
      end
    endcase
  end

  // unsupported funct falls through as a no-op
  assign isRtype = (opCode == `OP_RTYPE) && rtypeKnown;
  assign isAddiu = (opCode == `OP_ADDIU);
  assign isLw    = (opCode == `OP_LW);
  assign isSw    = (opCode == `OP_SW);
  assign isBeq   = (opCode == `OP_BEQ);
  assign isJ     = (opCode == `OP_J);

  always_ff @(posedge Load) begin
    if (reset) begin
      state       <= cpuPkg::Idle;
      branchTaken <= 1'b0;
    end else begin
      state <= nextState;
      // compare result, consumed in Retire
      if (state == cpuPkg::Execute) begin
        branchTaken <= zero;
      end
    end
  end

  always_comb begin
    nextState = state;
    memEnable = 1'b0;
    RW        = 1'b0;
    irLoad    = 1'b0;
    pcLoad    = 1'b0;
    npcLoad   = 1'b0;
    marLoad   = 1'b0;
    mdrLoad   = 1'b0;
    mdrSource = 1'b0;
    pcSelect  = 1'b0;
    immediate = 1'b0;
    rfSource  = 1'b0;
    regWrite  = 1'b0;
    jump      = 1'b0;
    branch    = 1'b0;
    aluSrc    = 2'd0;
    aluCode   = cpuPkg::ADD;
    retired   = 1'b0;
    case (state)
      cpuPkg::Idle: begin
        nextState = cpuPkg::FetchAddr;
      end
      cpuPkg::FetchAddr: begin
        // pc into mar
        pcSelect  = 1'b1;
        marLoad   = 1'b1;
        nextState = cpuPkg::FetchRead;
      end
      cpuPkg::FetchRead: begin
        memEnable = 1'b1;
        nextState = cpuPkg::FetchWait;
      end
      cpuPkg::FetchWait: begin
        // hold the read until MOC
        memEnable = 1'b1;
        if (MOC) begin
          irLoad    = 1'b1;
          nextState = cpuPkg::Decode;
        end
      end
      cpuPkg::Decode: begin
        // npc = pc + 1
        aluSrc    = 2'd2;
        npcLoad   = 1'b1;
        nextState = cpuPkg::Execute;
      end
      cpuPkg::Execute: begin
        if (isRtype) begin
          aluCode   = rtypeOp;
          nextState = cpuPkg::WriteBack;
        end else if (isAddiu) begin
          aluSrc    = 2'd1;
          immediate = 1'b1;
          nextState = cpuPkg::WriteBack;
        end else if (isLw || isSw) begin
          // effective address into mar, store data into mdr
          aluSrc    = 2'd1;
          immediate = 1'b1;
          marLoad   = 1'b1;
          mdrLoad   = isSw;
          nextState = cpuPkg::MemAddr;
        end else if (isBeq) begin
          aluCode   = cpuPkg::SUB;
          nextState = cpuPkg::Retire;
        end else begin
          nextState = cpuPkg::Retire;
        end
      end
      cpuPkg::MemAddr: begin
        memEnable = 1'b1;
        RW        = isSw;
        nextState = cpuPkg::MemWait;
      end
      cpuPkg::MemWait: begin
        memEnable = 1'b1;
        RW        = isSw;
        if (MOC) begin
          if (isLw) begin
            mdrLoad   = 1'b1;
            mdrSource = 1'b1;
            nextState = cpuPkg::WriteBack;
          end else begin
            nextState = cpuPkg::Retire;
          end
        end
      end
      cpuPkg::WriteBack: begin
        regWrite = 1'b1;
        if (isLw) begin
          rfSource  = 1'b1;
          immediate = 1'b1;
        end else if (isAddiu) begin
          aluSrc    = 2'd1;
          immediate = 1'b1;
        end else begin
          aluCode = rtypeOp;
        end
        nextState = cpuPkg::Retire;
      end
      cpuPkg::Retire: begin
        retired = 1'b1;
        pcLoad  = 1'b1;
        if (isJ) begin
          jump = 1'b1;
        end else if (isBeq && branchTaken) begin
          // target = npc + offset
          branch = 1'b1;
          aluSrc = 2'd3;
        end
        nextState = cpuPkg::FetchAddr;
      end
      default: begin
        nextState = cpuPkg::Idle;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/cpuCore.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore (
  input  wire              Load,
  input  wire              reset,
  input  wire              progWrite,
  input  cpuPkg::memAddr_t progAddr,
  input  cpuPkg::word_t    progData,
  output logic             storeStrobe,
  output cpuPkg::memAddr_t storeAddr,
  output cpuPkg::word_t    storeData,
  output logic             retired,
  output cpuPkg::memAddr_t retiredPc
);

  logic             memEnable;
  logic             RW;
  logic             MOC;
  logic             irLoad;
  logic             pcLoad;
  logic             npcLoad;
  logic             marLoad;
  logic             mdrLoad;
  logic             mdrSource;
  logic             pcSelect;
  logic             immediate;
  logic             rfSource;
  logic             regWrite;
  logic             jump;
  logic             branch;
  logic [1:0]       aluSrc;
  cpuPkg::aluOp_t   aluCode;
  cpuPkg::opcode_t  opCode;
  cpuPkg::opcode_t  funct;
  logic             zero;
  cpuPkg::memAddr_t memAddr;
  cpuPkg::word_t    memWriteData;
  cpuPkg::word_t    memRead;
  cpuPkg::memAddr_t pc;

  controlUnit ctrl (
    .Load      (Load),
    .reset     (reset),
    .opCode    (opCode),
    .funct     (funct),
    .zero      (zero),
    .MOC       (MOC),
    .memEnable (memEnable),
    .RW        (RW),
    .irLoad    (irLoad),
    .pcLoad    (pcLoad),
    .npcLoad   (npcLoad),
    .marLoad   (marLoad),
    .mdrLoad   (mdrLoad),
    .mdrSource (mdrSource),
    .pcSelect  (pcSelect),
    .immediate (immediate),
    .rfSource  (rfSource),
    .regWrite  (regWrite),
    .jump      (jump),
    .branch    (branch),
    .aluSrc    (aluSrc),
    .aluCode   (aluCode),
    .retired   (retired)
  );

  datapath dp (
    .Load         (Load),
    .reset        (reset),
    .pcLoad       (pcLoad),
    .npcLoad      (npcLoad),
    .irLoad       (irLoad),
    .marLoad      (marLoad),
    .mdrLoad      (mdrLoad),
    .pcSelect     (pcSelect),
    .immediate    (immediate),
    .aluSrc       (aluSrc),
    .aluCode      (aluCode),
    .rfSource     (rfSource),
    .regWrite     (regWrite),
    .mdrSource    (mdrSource),
    .jump         (jump),
    .branch       (branch),
    .memRead      (memRead),
    .opCode       (opCode),
    .funct        (funct),
    .zero         (zero),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .pc           (pc)
  );

  memoryUnit mem (
    .Load      (Load),
    .reset     (reset),
    .memEnable (memEnable),
    .RW        (RW),
    .addr      (memAddr),
    .writeData (memWriteData),
    .progWrite (progWrite),
    .progAddr  (progAddr),
    .progData  (progData),
    .readData  (memRead),
    .MOC       (MOC)
  );

  // write completes in the MOC cycle, mar and mdr still hold it
  assign storeStrobe = MOC & RW;
  assign storeAddr   = memAddr;
  assign storeData   = memWriteData;

  // pc still holds the retiring instruction during Retire
  assign retiredPc = pc;

endmodule

`default_nettype wire

/* src/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  // one data or instruction word
  typedef logic [31:0] word_t;

  // register file index
  typedef logic [4:0] regAddr_t;

  // opcode or funct field
  typedef logic [5:0] opcode_t;

  // word address into the 256-word memory
  typedef logic [7:0] memAddr_t;

  // alu operation select
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    SLT
  } aluOp_t;

  // multicycle control states
  typedef enum logic [3:0] {
    Idle,
    FetchAddr,
    FetchRead,
    FetchWait,
    Decode,
    Execute,
    MemAddr,
    MemWait,
    WriteBack,
    Retire
  } ctrlState_t;

endpackage

`default_nettype wire

/* src/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_ADDIU 6'h09
`define OP_LW    6'h23
`define OP_SW    6'h2b

// funct codes under OP_RTYPE
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

// memory size in words
`define MEM_DEPTH 256

// cycles enabled before MOC is raised
`define MEM_WAIT 2

`endif

/* src/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath (
  input  wire              Load,
  input  wire              reset,
  input  wire              pcLoad,
  input  wire              npcLoad,
  input  wire              irLoad,
  input  wire              marLoad,
  input  wire              mdrLoad,
  input  wire              pcSelect,
  input  wire              immediate,
  input  wire [1:0]        aluSrc,
  input  cpuPkg::aluOp_t   aluCode,
  input  wire              rfSource,
  input  wire              regWrite,
  input  wire              mdrSource,
  input  wire              jump,
  input  wire              branch,
  input  cpuPkg::word_t    memRead,
  output cpuPkg::opcode_t  opCode,
  output cpuPkg::opcode_t  funct,
  output logic             zero,
  output cpuPkg::memAddr_t memAddr,
  output cpuPkg::word_t    memWriteData,
  output cpuPkg::memAddr_t pc
);

  cpuPkg::memAddr_t pcReg;
  cpuPkg::memAddr_t npcReg;
  cpuPkg::memAddr_t marReg;
  cpuPkg::memAddr_t pcIn;
  cpuPkg::word_t    irReg;
  cpuPkg::word_t    mdrReg;
  cpuPkg::word_t    regFile [32];
  cpuPkg::regAddr_t rsAddr;
  cpuPkg::regAddr_t rtAddr;
  cpuPkg::regAddr_t rdAddr;
  cpuPkg::regAddr_t writeAddr;
  cpuPkg::word_t    regA;
  cpuPkg::word_t    regB;
  cpuPkg::word_t    signExt;
  cpuPkg::word_t    aluA;
  cpuPkg::word_t    aluB;
  cpuPkg::word_t    aluResult;
  cpuPkg::word_t    rfData;

  // instruction fields
  assign opCode  = irReg[31:26];
  assign rsAddr  = irReg[25:21];
  assign rtAddr  = irReg[20:16];
  assign rdAddr  = irReg[15:11];
  assign funct   = irReg[5:0];
  assign signExt = {{16{irReg[15]}}, irReg[15:0]};

  // I-format writes rt
  assign writeAddr = immediate ? rtAddr : rdAddr;
  assign rfData    = rfSource ? mdrReg : aluResult;

  assign regA = regFile[rsAddr];
  assign regB = regFile[rtAddr];

  // operand a follows the operand b select
  always_comb begin
    case (aluSrc)
      2'd2:    aluA = cpuPkg::word_t'(pcReg);
      2'd3:    aluA = cpuPkg::word_t'(npcReg);
      default: aluA = regA;
    endcase
  end

  always_comb begin
    case (aluSrc)
      2'd0:    aluB = regB;
      2'd2:    aluB = 32'd1;
      default: aluB = signExt;
    endcase
  end

  alu aluInst (
    .a      (aluA),
    .b      (aluB),
    .op     (aluCode),
    .result (aluResult),
    .zero   (zero)
  );

  // jump target is the low index bits, branch target from the alu
  assign pcIn = jump ? irReg[7:0] : (branch ? aluResult[7:0] : npcReg);

  always_ff @(posedge Load) begin
    if (reset) begin
      pcReg <= '0;
      irReg <= '0;
    end else begin
      if (pcLoad) begin
        pcReg <= pcIn;
      end
      if (irLoad) begin
        irReg <= memRead;
      end
    end
  end

  always_ff @(posedge Load) begin
    if (npcLoad) begin
      npcReg <= aluResult[7:0];
    end
    if (marLoad) begin
      marReg <= pcSelect ? pcReg : aluResult[7:0];
    end
    if (mdrLoad) begin
      mdrReg <= mdrSource ? memRead : regB;
    end
  end

  // register 0 is never written
  always_ff @(posedge Load) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regFile[i] <= '0;
      end
    end else if (regWrite && (writeAddr != 5'd0)) begin
      regFile[writeAddr] <= rfData;
    end
  end

  assign memAddr      = marReg;
  assign memWriteData = mdrReg;
  assign pc           = pcReg;

endmodule

`default_nettype wire

/* src/memoryUnit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module memoryUnit (
  input  wire              Load,
  input  wire              reset,
  input  wire              memEnable,
  input  wire              RW,
  input  cpuPkg::memAddr_t addr,
  input  cpuPkg::word_t    writeData,
  input  wire              progWrite,
  input  cpuPkg::memAddr_t progAddr,
  input  cpuPkg::word_t    progData,
  output cpuPkg::word_t    readData,
  output logic             MOC
);

  localparam int waitBits = $clog2(`MEM_WAIT + 1);

  cpuPkg::word_t       ram [`MEM_DEPTH];
  logic [waitBits-1:0] waitCount;
  logic                accessDone;

  // last wait cycle of an access before MOC
  assign accessDone = memEnable && !MOC && (waitCount == waitBits'(`MEM_WAIT));

  always_ff @(posedge Load) begin
    if (reset) begin
      waitCount <= '0;
      MOC       <= 1'b0;
    end else begin
      // single-cycle strobe
      MOC <= 1'b0;
      if (!memEnable) begin
        waitCount <= '0;
      end else if (accessDone) begin
        waitCount <= '0;
        MOC       <= 1'b1;
      end else if (!MOC) begin
        waitCount <= waitCount + waitBits'(1);
      end
    end
  end

  // program load only while in reset
  always_ff @(posedge Load) begin
    if (reset) begin
      if (progWrite) begin
        ram[progAddr] <= progData;
      end
    end else if (accessDone && RW) begin
      ram[addr] <= writeData;
    end
  end

  // read word valid alongside MOC
  always_ff @(posedge Load) begin
    if (accessDone && !RW) begin
      readData <= ram[addr];
    end
  end

endmodule

`default_nettype wire

/* test/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen (
  input  wire  holdReset,
  output logic Load,
  output logic reset
);

  // cycles since the hold dropped
  int holdCount;

  // 20 ns period, first rising edge at 10 ns
  initial begin
    Load = 1'b0;
    forever #10 Load = ~Load;
  end

  always @(negedge Load) begin
    if (holdReset) begin
      holdCount <= 0;
    end else if (holdCount < 5) begin
      holdCount <= holdCount + 1;
    end
  end

  // reset stays up for 5 cycles past the hold
  assign reset = holdReset || (holdCount < 5);

endmodule

`default_nettype wire

/* test/cpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpuTb;

  localparam int numProgs  = 4;
  localparam int maxWords  = 24;
  localparam int maxStores = 8;

  logic             Load;
  logic             reset;
  logic             holdReset;
  logic             progWrite;
  cpuPkg::memAddr_t progAddr;
  cpuPkg::word_t    progData;
  logic             storeStrobe;
  cpuPkg::memAddr_t storeAddr;
  cpuPkg::word_t    storeData;
  logic             retired;
  cpuPkg::memAddr_t retiredPc;

  // program table, filled once before the run
  cpuPkg::word_t    progWords   [numProgs][maxWords];
  int               progLen     [numProgs];
  cpuPkg::memAddr_t retirePcs   [numProgs][maxWords];
  int               retireCount [numProgs];
  cpuPkg::memAddr_t storeAddrs  [numProgs][maxStores];
  cpuPkg::word_t    storeValues [numProgs][maxStores];
  int               storeCount  [numProgs];
  int               building;

  clockGen clocks (
    .holdReset (holdReset),
    .Load      (Load),
    .reset     (reset)
  );

  cpuCore dut (
    .Load        (Load),
    .reset       (reset),
    .progWrite   (progWrite),
    .progAddr    (progAddr),
    .progData    (progData),
    .storeStrobe (storeStrobe),
    .storeAddr   (storeAddr),
    .storeData   (storeData),
    .retired     (retired),
    .retiredPc   (retiredPc)
  );

  task automatic reportValue(input string name, input cpuPkg::word_t expected,
                             input cpuPkg::word_t actual);
    $display("ERR time %0t: %s expected %h, actual %h", $time, name, expected, actual);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic reportText(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // MIPS instruction formats
  function automatic cpuPkg::word_t rFormat(input int rs, input int rt, input int rd,
                                            input cpuPkg::opcode_t fn);
    return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic cpuPkg::word_t iFormat(input cpuPkg::opcode_t op, input int rs,
                                            input int rt, input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic cpuPkg::word_t jFormat(input int target);
    return {`OP_J, 26'(target)};
  endfunction

  function automatic cpuPkg::word_t signExtend(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  task automatic emit(input cpuPkg::word_t instr);
    progWords[building][progLen[building]] = instr;
    progLen[building]++;
  endtask

  // instruction that must retire, in emission order
  task automatic emitRetired(input cpuPkg::word_t instr);
    retirePcs[building][retireCount[building]] = cpuPkg::memAddr_t'(progLen[building]);
    retireCount[building]++;
    emit(instr);
  endtask

  task automatic expectStore(input cpuPkg::memAddr_t addr, input cpuPkg::word_t value);
    storeAddrs[building][storeCount[building]]  = addr;
    storeValues[building][storeCount[building]] = value;
    storeCount[building]++;
  endtask

  task automatic buildTable();
    cpuPkg::word_t a;
    cpuPkg::word_t b;
    cpuPkg::word_t r;
    cpuPkg::word_t sum;
    logic [15:0]   negImm;
    logic [15:0]   posImm;
    logic [15:0]   anyImm;
    for (int p = 0; p < numProgs; p++) begin
      progLen[p]     = 0;
      retireCount[p] = 0;
      storeCount[p]  = 0;
    end
    // R-type arithmetic on values from ADDIU
    building = 0;
    a = 32'd25;
    b = signExtend(16'hfff9);
    emitRetired(iFormat(`OP_ADDIU, 0, 1, 16'd25));
    emitRetired(iFormat(`OP_ADDIU, 0, 2, 16'hfff9));
    emitRetired(rFormat(1, 2, 3, `FN_ADDU));
    emitRetired(iFormat(`OP_SW, 0, 3, 16'h0080));
    expectStore(8'h80, a + b);
    emitRetired(rFormat(1, 2, 4, `FN_SUBU));
    emitRetired(iFormat(`OP_SW, 0, 4, 16'h0081));
    expectStore(8'h81, a - b);
    emitRetired(rFormat(1, 2, 5, `FN_AND));
    emitRetired(iFormat(`OP_SW, 0, 5, 16'h0082));
    expectStore(8'h82, a & b);
    emitRetired(rFormat(1, 2, 6, `FN_OR));
    emitRetired(iFormat(`OP_SW, 0, 6, 16'h0083));
    expectStore(8'h83, a | b);
    // signed compare both ways
    emitRetired(rFormat(2, 1, 7, `FN_SLT));
    emitRetired(iFormat(`OP_SW, 0, 7, 16'h0084));
    expectStore(8'h84, {31'd0, $signed(b) < $signed(a)});
    emitRetired(rFormat(1, 2, 8, `FN_SLT));
    emitRetired(iFormat(`OP_SW, 0, 8, 16'h0085));
    expectStore(8'h85, {31'd0, $signed(a) < $signed(b)});
    // write to r0 is dropped
    emitRetired(rFormat(1, 1, 0, `FN_ADDU));
    emitRetired(iFormat(`OP_SW, 0, 0, 16'h0086));
    expectStore(8'h86, 32'd0);
    emitRetired(jFormat(progLen[building]));

    // random immediates, then load and store back
    building = 1;
    r = $urandom;
    negImm = {1'b1, r[14:0]};
    r = $urandom;
    posImm = {1'b0, r[14:0]};
    r = $urandom;
    anyImm = r[15:0];
    sum = signExtend(negImm) + signExtend(posImm);
    emitRetired(iFormat(`OP_ADDIU, 0, 1, negImm));
    emitRetired(iFormat(`OP_SW, 0, 1, 16'h0094));
    expectStore(8'h94, signExtend(negImm));
    emitRetired(iFormat(`OP_ADDIU, 1, 2, posImm));
    emitRetired(iFormat(`OP_SW, 0, 2, 16'h0090));
    expectStore(8'h90, sum);
    emitRetired(iFormat(`OP_ADDIU, 0, 3, anyImm));
    emitRetired(iFormat(`OP_SW, 0, 3, 16'h0091));
    expectStore(8'h91, signExtend(anyImm));
    emitRetired(iFormat(`OP_LW, 0, 4, 16'h0090));
    emitRetired(iFormat(`OP_SW, 0, 4, 16'h0092));
    expectStore(8'h92, sum);
    // base register plus offset reaches 0x91
    emitRetired(iFormat(`OP_ADDIU, 0, 5, 16'h0010));
    emitRetired(iFormat(`OP_LW, 5, 6, 16'h0081));
    emitRetired(iFormat(`OP_SW, 0, 6, 16'h0093));
    expectStore(8'h93, signExtend(anyImm));
    emitRetired(jFormat(progLen[building]));

    // BEQ not taken, BEQ taken, J over a store
    building = 2;
    emitRetired(iFormat(`OP_ADDIU, 0, 1, 16'd5));
    emitRetired(iFormat(`OP_ADDIU, 0, 2, 16'd5));
    emitRetired(iFormat(`OP_ADDIU, 0, 3, 16'd9));
    emitRetired(iFormat(`OP_BEQ, 1, 3, 16'd2));
    emitRetired(iFormat(`OP_SW, 0, 1, 16'h00a0));
    expectStore(8'ha0, 32'd5);
    // target is pc + 1 + 2
    emitRetired(iFormat(`OP_BEQ, 1, 2, 16'd2));
    emit(iFormat(`OP_SW, 0, 3, 16'h00a1));
    emit(iFormat(`OP_SW, 0, 3, 16'h00a2));
    emitRetired(jFormat(progLen[building] + 2));
    emit(iFormat(`OP_SW, 0, 3, 16'h00a3));
    emitRetired(iFormat(`OP_SW, 0, 3, 16'h00a4));
    expectStore(8'ha4, 32'd9);
    emitRetired(jFormat(progLen[building]));

    // unknown opcodes shaped like LUI and SB
    building = 3;
    emitRetired(iFormat(`OP_ADDIU, 0, 1, 16'h1234));
    emitRetired(iFormat(6'h0f, 0, 1, 16'habcd));
    emitRetired(iFormat(6'h28, 0, 1, 16'h00b1));
    emitRetired(iFormat(`OP_SW, 0, 1, 16'h00b0));
    expectStore(8'hb0, 32'h0000_1234);
    emitRetired(jFormat(progLen[building]));
  endtask

  // no retire and no store while in reset
  task automatic checkQuiet();
    assert (retired == 1'b0)
      else reportValue("retired", 32'd0, {31'd0, retired});
    assert (storeStrobe == 1'b0)
      else reportValue("storeStrobe", 32'd0, {31'd0, storeStrobe});
  endtask

  task automatic loadProgram(input int p);
    int count;
    holdReset <= 1'b1;
    count = 0;
    do begin
      @(negedge Load);
      count++;
      assert (count <= 10) else reportText("reset did not rise for the program load");
    end while (reset !== 1'b1);
    checkQuiet();
    for (int i = 0; i < progLen[p]; i++) begin
      progWrite <= 1'b1;
      progAddr  <= cpuPkg::memAddr_t'(i);
      progData  <= progWords[p][i];
      @(negedge Load);
      checkQuiet();
    end
    progWrite <= 1'b0;
    holdReset <= 1'b0;
    count = 0;
    do begin
      @(negedge Load);
      count++;
      if (reset) begin
        checkQuiet();
      end
      assert (count <= 10) else reportText("reset did not drop after the program load");
    end while (reset);
  endtask

  task automatic runProgram(input int p);
    int retireIdx;
    int storeIdx;
    int count;
    int limit;
    retireIdx = 0;
    storeIdx  = 0;
    count     = 0;
    limit     = (`MEM_WAIT + 10) * progLen[p];
    while (retireIdx < retireCount[p]) begin
      @(negedge Load);
      count++;
      if (storeStrobe) begin
        // a store beyond the list came from a skipped path
        assert (storeIdx < storeCount[p])
          else reportText($sformatf("program %0d stored to %h, no store expected", p, storeAddr));
        assert (storeAddr == storeAddrs[p][storeIdx])
          else reportValue("storeAddr", 32'(storeAddrs[p][storeIdx]), 32'(storeAddr));
        assert (storeData == storeValues[p][storeIdx])
          else reportValue("storeData", storeValues[p][storeIdx], storeData);
        storeIdx++;
      end
      if (retired) begin
        assert (retiredPc == retirePcs[p][retireIdx])
          else reportValue("retiredPc", 32'(retirePcs[p][retireIdx]), 32'(retiredPc));
        retireIdx++;
        count = 0;
      end
      assert (count <= limit)
        else reportText($sformatf("no retire came within %0d cycles in program %0d", limit, p));
    end
    assert (storeIdx == storeCount[p])
      else reportText($sformatf("program %0d made %0d of %0d stores", p, storeIdx,
                                storeCount[p]));
  endtask

  initial begin
    holdReset <= 1'b1;
    progWrite <= 1'b0;
    progAddr  <= '0;
    progData  <= '0;
    void'($urandom(3));
    buildTable();
    for (int p = 0; p < numProgs; p++) begin
      loadProgram(p);
      runProgram(p);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
